// File: common/wb_errgen_pkg.sv
`default_nettype none

package wb_errgen_pkg;

   //------------------------------
   // bus geometry
   //------------------------------
   localparam int TGT_CNT    = 4;                 // target select tag bits
   localparam int ADR_WIDTH  = 16;                // address bus
   localparam int DAT_WIDTH  = 16;                // read and write data
   localparam int SEL_WIDTH  = 2;                 // byte selects
   localparam int TGA_WIDTH  = 1;                 // address tags
   localparam int TGC_WIDTH  = 1;                 // cycle tags
   localparam int TGRD_WIDTH = 1;                 // read data tags
   localparam int TGWD_WIDTH = 1;                 // write data tags

   //------------------------------
   // initiator cycle tracker
   //------------------------------
   typedef enum logic [1:0] {
      CYC_RESET = 2'b00,                          // coming out of reset
      CYC_IDLE  = 2'b01,                          // nothing outstanding
      CYC_BUSY  = 2'b10,                          // forwarded request in flight
      CYC_ERROR = 2'b11                           // generated err due next
   } cyc_state_e;

   //------------------------------
   // bus bundles
   //------------------------------
   typedef struct packed {
      logic                  cyc;                 // bus cycle indicator
      logic                  stb;                 // access request
      logic                  we;                  // write enable
      logic                  lock;                // uninterruptable cycle
      logic [SEL_WIDTH-1:0]  sel;                 // write data selects
      logic [ADR_WIDTH-1:0]  adr;                 // address
      logic [DAT_WIDTH-1:0]  dat;                 // write data
      logic [TGA_WIDTH-1:0]  tga;                 // address tags
      logic [TGT_CNT-1:0]    tgtsel;              // target select tags
      logic [TGC_WIDTH-1:0]  tgc;                 // cycle tags
      logic [TGWD_WIDTH-1:0] tgd;                 // write data tags
   } wb_req_t;                                    // 45 bits

   typedef struct packed {
      logic                  ack;                 // cycle acknowledge
      logic                  err;                 // error response
      logic                  rty;                 // retry request
      logic                  stall;               // access delay
      logic [DAT_WIDTH-1:0]  dat;                 // read data
      logic [TGRD_WIDTH-1:0] tgd;                 // read data tags
   } wb_rsp_t;                                    // 21 bits

endpackage

`default_nettype wire

// File: verilog/itr_cycle_fsm.sv
`default_nettype none

module itr_cycle_fsm
   import wb_errgen_pkg::*;
(
   input  logic       clk_i,                      // module clock
   input  logic       rst_i,                      // async reset, active high
   input  logic       req_acc_i,                  // request accepted
   input  logic       req_inval_i,                // accepted request without target
   input  logic       rsp_done_i,                 // acknowledge on initiator side
   output cyc_state_e state_o                     // current tracker state
);

   cyc_state_e state_q;                           // state register
   cyc_state_e state_d;                           // next state
   cyc_state_e req_state;                         // where a new request leads

   //------------------------------
   // state register
   //------------------------------
   always_ff @(posedge clk_i or posedge rst_i)
   begin
      if (rst_i)
      begin
         state_q <= CYC_RESET;                    // hold in reset
      end
      else
      begin
         state_q <= state_d;
      end
   end

   // invalid requests wait for a generated err, valid ones for the target
   assign req_state = req_inval_i ? CYC_ERROR : CYC_BUSY;

   //------------------------------
   // transitions
   //------------------------------
   always_comb
   begin
      state_d = state_q;                          // stay by default
      case (state_q)
         CYC_RESET:
         begin
            state_d = CYC_IDLE;                   // one cycle after reset
         end
         CYC_IDLE:
         begin
            if (req_acc_i)
            begin
               state_d = req_state;               // first request of a cycle
            end
         end
         CYC_BUSY,
         CYC_ERROR:
         begin
            if (rsp_done_i)
            begin
               state_d = req_acc_i ? req_state : CYC_IDLE; // next one or drain
            end
         end
         default:
         begin
            state_d = CYC_RESET;                  // unreachable encodings
         end
      endcase
   end

   assign state_o = state_q;

   //------------------------------
   // checks
   //------------------------------
   // reset seen at an edge leaves the tracker in reset one edge later
   a_reset_hold : assert property (@(posedge clk_i) rst_i |=> state_q == CYC_RESET);

   // steering only flags validity on an accepted request
   a_inval_acc : assert property (@(posedge clk_i) disable iff (rst_i)
                                  req_inval_i |-> req_acc_i);

endmodule

`default_nettype wire

// File: verilog/req_steering.sv
`default_nettype none

module req_steering
   import wb_errgen_pkg::*;
(
   input  logic       clk_i,                      // module clock
   input  logic       rst_i,                      // async reset, active high
   input  wb_req_t    itr_req_i,                  // request from initiator
   output wb_rsp_t    itr_rsp_o,                  // response to initiator
   output wb_req_t    tgt_req_o,                  // request to target
   input  wb_rsp_t    tgt_rsp_i,                  // response from target
   input  cyc_state_e state_i,                    // tracker state
   output logic       req_acc_o,                  // request accepted
   output logic       req_inval_o,                // accepted request without target
   output logic       rsp_done_o                  // acknowledge to initiator
);

   logic no_tgt;                                  // no select bit set
   logic in_reset;                                // tracker still in reset
   logic tgt_done;                                // target answers this cycle
   logic inval_wait;                              // invalid request must wait

   assign no_tgt     = ~|itr_req_i.tgtsel;
   assign in_reset   = (state_i == CYC_RESET);
   assign tgt_done   = tgt_rsp_i.ack | tgt_rsp_i.err | tgt_rsp_i.rty;
   assign inval_wait = (state_i == CYC_BUSY) & ~tgt_done; // keep response order

   //------------------------------
   // forward path
   //------------------------------
   always_comb
   begin
      tgt_req_o     = itr_req_i;                  // payload unchanged
      tgt_req_o.cyc = itr_req_i.cyc & ~in_reset;
      tgt_req_o.stb = itr_req_i.stb & ~no_tgt & ~in_reset; // invalid never reaches target
   end

   //------------------------------
   // response path
   //------------------------------
   always_comb
   begin
      itr_rsp_o = tgt_rsp_i;                      // target response by default
      if (state_i == CYC_ERROR)
      begin
         itr_rsp_o.ack = 1'b0;                    // generated error
         itr_rsp_o.err = 1'b1;
         itr_rsp_o.rty = 1'b0;
         itr_rsp_o.dat = '0;
         itr_rsp_o.tgd = '0;
      end
      else if (in_reset)
      begin
         itr_rsp_o.ack = 1'b0;                    // quiet until idle
         itr_rsp_o.err = 1'b0;
         itr_rsp_o.rty = 1'b0;
      end

      // stall selection
      if (in_reset)
      begin
         itr_rsp_o.stall = 1'b1;
      end
      else if (no_tgt)
      begin
         itr_rsp_o.stall = inval_wait;            // target stall irrelevant here
      end
      else
      begin
         itr_rsp_o.stall = tgt_rsp_i.stall;       // straight through
      end
   end

   //------------------------------
   // tracker strobes
   //------------------------------
   assign req_acc_o   = itr_req_i.cyc & itr_req_i.stb & ~itr_rsp_o.stall;
   assign req_inval_o = req_acc_o & no_tgt;
   assign rsp_done_o  = itr_rsp_o.ack | itr_rsp_o.err | itr_rsp_o.rty;

   // target strobe only with a select bit
   a_no_stray_stb : assert property (@(posedge clk_i) disable iff (rst_i)
                                     tgt_req_o.stb |-> (itr_req_i.tgtsel != '0));

   // accepted invalid request puts the tracker in error and err out next cycle
   a_err_in_error : assert property (@(posedge clk_i) disable iff (rst_i)
                                     req_inval_o |=> (state_i == CYC_ERROR) && itr_rsp_o.err);

endmodule

`default_nettype wire

// File: verilog/wb_error_generator.sv
`default_nettype none

module wb_error_generator
   import wb_errgen_pkg::*;
(
   //------------------------------
   // clock and reset
   //------------------------------
   input  logic    clk_i,                         // module clock
   input  logic    rst_i,                         // async reset, active high

   //------------------------------
   // initiator side
   //------------------------------
   input  wb_req_t itr_req_i,                     // request from initiator
   output wb_rsp_t itr_rsp_o,                     // response to initiator

   //------------------------------
   // target side
   //------------------------------
   output wb_req_t tgt_req_o,                     // request to target
   input  wb_rsp_t tgt_rsp_i                      // response from target
);

   logic       req_acc;                           // request accepted this cycle
   logic       req_inval;                         // accepted request has no target
   logic       rsp_done;                          // ack, err or rty to initiator
   cyc_state_e state;                             // tracker state

   // cycle tracker
   itr_cycle_fsm u_itr_cycle_fsm
   (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .req_acc_i   (req_acc),
      .req_inval_i (req_inval),
      .rsp_done_i  (rsp_done),
      .state_o     (state)
   );

   // forwarding, stall and response select
   req_steering u_req_steering
   (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .itr_req_i   (itr_req_i),
      .itr_rsp_o   (itr_rsp_o),
      .tgt_req_o   (tgt_req_o),
      .tgt_rsp_i   (tgt_rsp_i),
      .state_i     (state),
      .req_acc_o   (req_acc),
      .req_inval_o (req_inval),
      .rsp_done_o  (rsp_done)
   );

endmodule

`default_nettype wire

// File: verification/tb_wb_error_generator.sv
`default_nettype none

module tb_wb_error_generator
   import wb_errgen_pkg::*;
();

   timeunit 1ns;
   timeprecision 100ps;

   //------------------------------
   // constants
   //------------------------------
   localparam string       GOLD_FILE   = "verification/wb_errgen_golden.txt";
   localparam int          GOLD_MAX    = 64;            // golden lines at most
   localparam int          ACC_TIMEOUT = 50;            // cycles per wait
   localparam logic [31:0] RNG_SEED    = 32'hbcfe;
   localparam logic [2:0]  KIND_ACK    = 3'b100;        // {ack, err, rty}

   typedef struct packed {
      logic [2:0]           kind;                       // expected {ack, err, rty}
      logic                 chk_dat;                    // read data compared
      logic [DAT_WIDTH-1:0] rdata;                      // expected read data
      int                   acc_cyc;                    // cycle of acceptance
   } exp_t;

   logic                 clk_i = 1'b0;
   logic                 rst_i;
   wb_req_t              itr_req;                       // initiator request
   wb_rsp_t              itr_rsp;
   wb_req_t              tgt_req;                       // forwarded request
   wb_rsp_t              tgt_rsp;                       // target model response

   logic [71:0]          golden [0:GOLD_MAX-1];         // packed golden lines
   exp_t                 exp_q [$];                     // responses still due
   int                   n_lines;
   int                   issued;                        // requests driven so far
   int                   acc_count;                     // requests accepted so far
   int                   cycle;
   int                   errors;
   int                   timeouts;
   logic                 started;                       // first request driven
   logic [2:0]           cur_kind;                      // current line, expected kind
   logic [2:0]           cur_react;                     // current line, target reaction
   logic                 cur_chk;
   logic [DAT_WIDTH-1:0] cur_rdata;

   wb_error_generator u_wb_error_generator
   (
      .clk_i     (clk_i),
      .rst_i     (rst_i),
      .itr_req_i (itr_req),
      .itr_rsp_o (itr_rsp),
      .tgt_req_o (tgt_req),
      .tgt_rsp_i (tgt_rsp)
   );

   always #4 clk_i = ~clk_i;                            // 8 ns period

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1103515245 + 32'd12345;
   endfunction

   // put one golden line on the initiator bus
   task automatic drive_request(input logic [71:0] ln);
      itr_req        = '0;
      itr_req.cyc    = 1'b1;
      itr_req.stb    = 1'b1;
      itr_req.we     = ln[64];
      itr_req.adr    = ln[63:48];
      itr_req.dat    = ln[47:32];
      itr_req.sel    = ln[29:28];
      itr_req.tgtsel = ln[27:24];                       // zero means no target
      cur_react      = ln[22:20];
      cur_kind       = ln[18:16];
      cur_rdata      = ln[15:0];
      cur_chk        = ~ln[64] & (ln[18:16] == KIND_ACK); // data only on acked reads
      started        = 1'b1;
   endtask

   //------------------------------
   // initiator driver
   //------------------------------
   initial
   begin : driver
      logic [71:0] ln;
      int          waited;
      int          i;
      logic        aborted;
      rst_i          = 1'b1;
      itr_req        = '0;
      itr_req.cyc    = 1'b1;                            // request held through reset
      itr_req.stb    = 1'b1;
      itr_req.tgtsel = '1;
      started        = 1'b0;
      issued         = 0;
      timeouts       = 0;
      cur_kind       = '0;
      cur_react      = '0;
      cur_chk        = 1'b0;
      cur_rdata      = '0;
      aborted        = 1'b0;
      for (i = 0; i < GOLD_MAX; i++)
      begin
         golden[i] = '1;                                // end marker
      end
      $readmemh(GOLD_FILE, golden);
      n_lines = 0;
      while (n_lines < GOLD_MAX && golden[n_lines] != '1)
      begin
         n_lines++;
      end

      repeat (10) @(posedge clk_i);
      #1;
      rst_i = 1'b0;
      @(posedge clk_i);                                 // tracker leaves reset
      #1;
      itr_req = '0;

      for (i = 0; i < n_lines && !aborted; i++)
      begin
         ln = golden[i];
         if (ln[71:68] != 4'h0)
         begin
            itr_req = '0;                               // idle gap
            repeat (ln[71:68])
            begin
               @(posedge clk_i);
               #1;
            end
         end
         drive_request(ln);
         issued++;
         waited = 0;
         while (acc_count < issued && waited < ACC_TIMEOUT)
         begin
            @(posedge clk_i);                           // monitor counted at negedge
            waited++;
         end
         #1;
         if (acc_count < issued)
         begin
            timeouts++;
            $display("Timeout at %0t: request %0d was never accepted", $time, i);
            aborted = 1'b1;
         end
      end
      itr_req = '0;

      // drain the last responses
      waited = 0;
      while (!aborted && exp_q.size() != 0 && waited < ACC_TIMEOUT)
      begin
         @(posedge clk_i);
         waited++;
      end
      if (!aborted && exp_q.size() != 0)
      begin
         timeouts++;
         $display("Timeout at %0t: %0d responses never arrived", $time, exp_q.size());
      end
      if (n_lines == 0)
      begin
         $display("The golden file holds no transactions");
      end

      $display("errors: %0d  timeouts: %0d", errors, timeouts);
      if (errors == 0 && timeouts == 0 && n_lines != 0)
      begin
         $display("** PASS **");
      end
      else
      begin
         $display("** FAIL **");
      end
      $finish;
   end

   //------------------------------
   // target model
   //------------------------------
   initial
   begin : target
      logic [DAT_WIDTH-1:0] mem [0:15];                 // indexed by adr[3:0]
      logic [31:0]          rng;
      int                   stall_left;                 // stall cycles still owed
      int                   i;
      logic                 in_rst;                     // reset seen at the last negedge
      logic                 hit;                        // request taken this cycle
      logic                 held;                       // request stalled this cycle
      logic                 hit_we;
      logic [3:0]           hit_idx;
      logic [DAT_WIDTH-1:0] hit_dat;
      logic [SEL_WIDTH-1:0] hit_sel;
      logic [2:0]           hit_react;
      tgt_rsp   = '0;
      hit_we    = 1'b0;
      hit_idx   = '0;
      hit_dat   = '0;
      hit_sel   = '0;
      hit_react = '0;
      for (i = 0; i < 16; i++)
      begin
         mem[i] = 16'hd000 ^ 16'(i * 16'h0111);         // fill from whole index
      end
      rng        = lcg_next(RNG_SEED);
      stall_left = int'((rng >> 16) % 3);
      forever
      begin
         @(negedge clk_i);
         in_rst = rst_i;
         hit  = !rst_i && tgt_req.cyc && tgt_req.stb && !tgt_rsp.stall;
         held = !rst_i && tgt_req.cyc && tgt_req.stb && tgt_rsp.stall;
         if (hit)
         begin
            hit_we    = tgt_req.we;
            hit_idx   = tgt_req.adr[3:0];
            hit_dat   = tgt_req.dat;
            hit_sel   = tgt_req.sel;
            hit_react = cur_react;                      // reaction of this golden line
         end
         @(posedge clk_i);
         #1;
         tgt_rsp.ack = in_rst;                          // stray ack hidden by the reset
         tgt_rsp.err = 1'b0;
         tgt_rsp.rty = 1'b0;
         tgt_rsp.dat = '0;
         tgt_rsp.tgd = '0;
         if (hit)
         begin
            {tgt_rsp.ack, tgt_rsp.err, tgt_rsp.rty} = hit_react; // answer one cycle later
            if (hit_we)
            begin
               if (hit_react == KIND_ACK && hit_sel[0])
               begin
                  mem[hit_idx][7:0] = hit_dat[7:0];
               end
               if (hit_react == KIND_ACK && hit_sel[1])
               begin
                  mem[hit_idx][15:8] = hit_dat[15:8];
               end
            end
            else
            begin
               tgt_rsp.dat = mem[hit_idx];
            end
            rng        = lcg_next(rng);
            stall_left = int'((rng >> 16) % 3);         // 0 to 2 for the next one
         end
         else if (held && stall_left != 0)
         begin
            stall_left--;
         end
         tgt_rsp.stall = (stall_left != 0);
      end
   end

   //------------------------------
   // monitor and checks
   //------------------------------
   initial
   begin : monitor
      exp_t       e;
      logic [2:0] rsp_kind;
      logic       acc;
      cycle     = 0;
      acc_count = 0;
      errors    = 0;
      forever
      begin
         @(negedge clk_i);                              // mid cycle, all settled
         cycle++;
         rsp_kind = {itr_rsp.ack, itr_rsp.err, itr_rsp.rty};
         if (!started && (rsp_kind != 3'b000 || tgt_req.cyc || tgt_req.stb))
         begin
            errors++;
            $display("Mismatch at %0t: bus active before the first request", $time);
         end
         if (rsp_kind != 3'b000)
         begin
            if (exp_q.size() == 0)
            begin
               errors++;
               $display("Response at %0t arrived with no request outstanding", $time);
            end
            else
            begin
               e = exp_q.pop_front();                   // responses in issue order
               if (rsp_kind != e.kind)
               begin
                  errors++;
                  $display("Mismatch at %0t: response %b, expected %b", $time, rsp_kind,
                           e.kind);
               end
               if (cycle != e.acc_cyc + 1)
               begin
                  errors++;
                  $display("Mismatch at %0t: response %0d cycles after acceptance", $time,
                           cycle - e.acc_cyc);
               end
               if (e.chk_dat && itr_rsp.dat != e.rdata)
               begin
                  errors++;
                  $display("Mismatch at %0t: read data %h, expected %h", $time,
                           itr_rsp.dat, e.rdata);
               end
            end
         end
         if (tgt_req.stb && tgt_req.tgtsel == '0)
         begin
            errors++;
            $display("Mismatch at %0t: target strobe without a select bit", $time);
         end
         acc = !rst_i && itr_req.cyc && itr_req.stb && !itr_rsp.stall;
         if (acc)
         begin
            if (itr_req.tgtsel != '0)
            begin
               if (!tgt_req.stb || tgt_req.we != itr_req.we || tgt_req.adr != itr_req.adr ||
                   tgt_req.dat != itr_req.dat || tgt_req.sel != itr_req.sel ||
                   tgt_req.tgtsel != itr_req.tgtsel)
               begin
                  errors++;
                  $display("Mismatch at %0t: forwarded request differs at adr %h", $time,
                           itr_req.adr);
               end
            end
            else if (exp_q.size() != 0)
            begin
               errors++;
               $display("Mismatch at %0t: invalid request taken ahead of a response", $time);
            end
            e.kind    = cur_kind;
            e.chk_dat = cur_chk;
            e.rdata   = cur_rdata;
            e.acc_cyc = cycle;
            exp_q.push_back(e);
            acc_count++;
         end
      end
   end

endmodule

`default_nettype wire

// File: verification/wb_errgen_golden.txt
// gap_we_adr_dat_sel_tgtsel_react_kind_rdata, hex; gap is idle cycles before issue
// react is the target reaction, kind the initiator response: 4 ack, 2 err, 1 rty
3_1_0021_1234_3_1_4_4_0000
0_1_0022_abcd_3_2_4_4_0000
1_0_0021_0000_3_1_4_4_1234
0_0_0022_0000_3_4_4_4_abcd
2_1_0023_5566_3_8_2_2_0000
0_0_0023_0000_3_8_1_1_0000
2_1_0024_0f0f_3_0_0_2_0000
0_0_0021_0000_3_0_0_2_0000
1_1_0025_7788_3_3_4_4_0000
0_1_0026_99aa_3_0_0_2_0000
2_0_0025_0000_3_5_4_4_7788
0_0_0026_0000_3_0_0_2_0000
0_1_0027_1111_3_0_0_2_0000
0_0_0027_0000_3_0_0_2_0000
0_1_0027_2468_3_2_4_4_0000
0_0_0027_0000_3_2_4_4_2468
1_1_0028_ffff_3_4_4_4_0000
0_1_0028_0012_1_4_4_4_0000
0_0_0028_0000_3_4_4_4_ff12
2_0_0022_0000_3_1_1_1_0000
0_0_0022_0000_3_1_4_4_abcd
0_1_002a_0000_3_0_0_2_0000
0_0_0021_0000_3_8_4_4_1234
3_1_002b_c3c3_3_f_4_4_0000
0_0_002b_0000_3_f_4_4_c3c3
1_0_002b_0000_3_0_0_2_0000
0_1_002c_5a5a_3_1_4_4_0000
0_0_002c_0000_3_1_4_4_5a5a

// File: wb_error_generator.f
common/wb_errgen_pkg.sv
verilog/itr_cycle_fsm.sv
verilog/req_steering.sv
verilog/wb_error_generator.sv
verification/tb_wb_error_generator.sv

// File: Makefile
TOOL  = verilator
FLAGS = --binary --timing --assert --timescale 1ns/100ps -j 0
TOP   = tb_wb_error_generator
FLIST = wb_error_generator.f
LOG   = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -qxF '** PASS **' $(LOG)

clean:
	rm -rf obj_dir $(LOG)
